//--- Makefile
# Verilator build and run for the cache testbench.

VERILATOR       ?= verilator
TOP             ?= tb_cache_subsystem
FILE_LIST       ?= build.f
BUILD_DIR       ?= obj_dir
READ_LATENCY    ?= 4
VERILATOR_FLAGS ?= --binary --timing --assert

.PHONY: simulate clean

# A failing check ends the run with $fatal, which gives a nonzero exit status.
simulate:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Gread_latency=$(READ_LATENCY) \
		--Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- build.f
cache_pkg.sv
cache_tag_array.sv
cache_data_array.sv
cache_control.sv
cache_subsystem.sv
tb_main_memory.sv
tb_cache_subsystem.sv

//--- cache_control.sv
`timescale 1ns/1ps

module cache_control (
  input  logic                  clk,            // Cache clock.
  input  logic                  reset,          // Returns the FSM to idle.
  input  logic                  cpu_read,       // CPU read request.
  input  cache_pkg::addr_t      cpu_address,    // Held by the CPU while stall is high.
  input  cache_pkg::tag_entry_t way0_entry,     // Current entry of way 0 for the set.
  input  cache_pkg::tag_entry_t way1_entry,     // Current entry of way 1 for the set.
  input  logic                  way0_match,     // Way 0 hit.
  input  logic                  way1_match,     // Way 1 hit.
  input  cache_pkg::word_t      mem_data,       // Returned memory word.
  input  logic                  mem_data_valid, // Qualifies mem_data.
  output logic                  stall,          // Holds the CPU pipeline.
  output logic                  tag_write,      // Writes both tag entries of the set.
  output cache_pkg::tag_entry_t way0_entry_in,  // Next entry for way 0.
  output cache_pkg::tag_entry_t way1_entry_in,  // Next entry for way 1.
  output logic                  data_write,     // Writes one word into the data array.
  output logic                  write_way,      // Victim way being filled.
  output cache_pkg::offset_t    write_offset,   // Word position inside the line.
  output cache_pkg::word_t      fill_data,      // Word to store.
  output logic                  mem_read,       // One word request to memory.
  output cache_pkg::addr_t      mem_address     // Byte address of the request.
);
  import cache_pkg::*;

  localparam count_t line_count = count_t'(line_words); // Terminal value of both counters.

  fill_state_t state;           // Current FSM state.
  fill_state_t next_state;      // FSM state after this edge.
  logic        hit;             // Either way holds the line.
  logic        miss;            // A read that no way holds.
  logic        start_fill;      // A miss seen while idle.
  logic        requests_done;   // All eight requests are out.
  logic        fill_done;       // All eight words are in the data array.
  logic        victim_way;      // Way chosen for replacement at the miss.
  logic        used_way;        // Way that becomes most recently used.
  tag_t        miss_tag;        // Tag written for the new line.
  count_t      request_count;   // Requests issued so far.
  count_t      fill_count;      // Words written so far.
  addr_t       request_address; // Address of the next request.

  assign hit        = way0_match | way1_match;
  assign miss       = cpu_read & ~hit;
  assign start_fill = (state == idle) & miss;
  assign miss_tag   = addr_tag(cpu_address); // CPU holds its address through the fill.

  //////////////////////////////////////////////////////////////////////
  // Idle and fill FSM.
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state; // Stay unless a transition below fires.
    stall      = 1'b0;  // CPU runs freely by default.
    tag_write  = 1'b0;  // No tag update by default.
    case (state)
      idle: begin
        stall     = miss;            // Stall rises in the miss cycle itself.
        tag_write = cpu_read & hit;  // A hit refreshes the LRU bits.
        if (miss) begin
          next_state = fill;
        end
      end
      fill: begin
        stall     = 1'b1;      // Held until the lookup hits back in idle.
        tag_write = fill_done; // New tag goes in after the last word.
        if (fill_done) begin
          next_state = idle;
        end
      end
      default: begin
        next_state = idle; // Recover from an illegal encoding.
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Request side. One read per cycle until eight are out.
  //////////////////////////////////////////////////////////////////////
  assign requests_done = (request_count == line_count);
  assign mem_read      = (state == fill) & ~requests_done;
  assign mem_address   = request_address;

  always_ff @(posedge clk) begin
    if (reset) begin
      request_count   <= '0;
      request_address <= '0;
    end else if (start_fill) begin
      request_count   <= '0;
      request_address <= line_base(cpu_address); // Fill starts at word 0 of the line.
    end else if (mem_read) begin
      request_count   <= request_count + count_t'(1);
      request_address <= request_address + addr_t'(2); // Next 16-bit word.
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Return side. Counts words as memory hands them back in order.
  //////////////////////////////////////////////////////////////////////
  assign fill_done    = (fill_count == line_count);
  assign data_write   = (state == fill) & mem_data_valid & ~fill_done;
  assign write_offset = offset_t'(fill_count); // Words return in request order.
  assign write_way    = victim_way;
  assign fill_data    = mem_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      fill_count <= '0;
    end else if (start_fill) begin
      fill_count <= '0;
    end else if (data_write) begin
      fill_count <= fill_count + count_t'(1);
    end
  end

  // Way 0 is replaced when its LRU bit says it is the older way.
  always_ff @(posedge clk) begin
    if (reset) begin
      victim_way <= 1'b0;
    end else if (start_fill) begin
      victim_way <= ~entry_lru(way0_entry);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Tag entry generation.
  //////////////////////////////////////////////////////////////////////
  assign used_way = (state == fill) ? victim_way : way1_match; // Filled way or hit way.

  always_comb begin
    // The used way gets LRU clear, the other way gets LRU set.
    way0_entry_in = make_entry(entry_tag(way0_entry), entry_valid(way0_entry), used_way);
    way1_entry_in = make_entry(entry_tag(way1_entry), entry_valid(way1_entry), ~used_way);
    if (state == fill) begin
      if (victim_way) begin
        way1_entry_in = make_entry(miss_tag, 1'b1, 1'b0); // New line in way 1.
      end else begin
        way0_entry_in = make_entry(miss_tag, 1'b1, 1'b0); // New line in way 0.
      end
    end
  end

endmodule

//--- cache_data_array.sv
`timescale 1ns/1ps

module cache_data_array (
  input  logic               clk,          // Cache clock.
  input  cache_pkg::index_t  index,        // Set for both the read and the write.
  input  cache_pkg::offset_t read_offset,  // Word of the line to read.
  input  logic               read_way,     // Way to read from.
  input  logic               data_write,   // Writes fill_data at the clock edge.
  input  logic               write_way,    // Way being filled.
  input  cache_pkg::offset_t write_offset, // Word of the line being filled.
  input  cache_pkg::word_t   fill_data,    // Word returned by memory.
  output cache_pkg::word_t   read_data     // Word for the CPU.
);
  import cache_pkg::*;

  localparam int depth     = 2 * num_sets * line_words; // Two ways of 64 lines of 8 words.
  localparam int slot_bits = $clog2(depth);             // Ten bits address the store.

  word_t                storage [depth]; // Line data of both ways.
  logic [slot_bits-1:0] read_slot;       // Location of the word being read.
  logic [slot_bits-1:0] write_slot;      // Location of the word being filled.

  //////////////////////////////////////////////////////////////////////
  // Location is way, then set, then word.
  //////////////////////////////////////////////////////////////////////
  assign read_slot  = {read_way, index, read_offset};
  assign write_slot = {write_way, index, write_offset};

  // The read is asynchronous so a hit returns data in the lookup cycle.
  assign read_data = storage[read_slot];

  always_ff @(posedge clk) begin
    if (data_write) begin
      storage[write_slot] <= fill_data; // One word per returned memory beat.
    end
  end

endmodule

//--- cache_pkg.sv
package cache_pkg;

  //////////////////////////////////////////////////////////////////////
  // Geometry of the cache.
  //////////////////////////////////////////////////////////////////////
  localparam int line_words = 8; // Words per cache line.
  localparam int num_sets   = 64; // Sets per way.

  typedef logic [15:0] addr_t;     // Byte address on the CPU and memory side.
  typedef logic [15:0] word_t;     // One data word.
  typedef logic [5:0]  tag_t;      // Address bits 15..10.
  typedef logic [5:0]  index_t;    // Address bits 9..4, selects the set.
  typedef logic [2:0]  offset_t;   // Address bits 3..1, selects the word in a line.
  typedef logic [3:0]  count_t;    // Word counter, wide enough to hold line_words.
  typedef logic [7:0]  tag_entry_t; // Tag in 7..2, valid in 1, LRU in 0.

  typedef enum logic {
    idle, // Waiting for a CPU read that misses.
    fill  // Requesting and collecting the words of one line.
  } fill_state_t;

  //////////////////////////////////////////////////////////////////////
  // Field helpers for addresses and tag entries.
  //////////////////////////////////////////////////////////////////////
  function automatic tag_t addr_tag(addr_t address);
    return address[15:10]; // Upper six bits form the tag.
  endfunction

  function automatic index_t addr_index(addr_t address);
    return address[9:4]; // Six bits pick one of the 64 sets.
  endfunction

  function automatic offset_t addr_offset(addr_t address);
    return address[3:1]; // Bit 0 is the byte inside the word.
  endfunction

  function automatic addr_t line_base(addr_t address);
    return {address[15:4], 4'h0}; // First byte of the line.
  endfunction

  function automatic tag_t entry_tag(tag_entry_t entry);
    return entry[7:2];
  endfunction

  function automatic logic entry_valid(tag_entry_t entry);
    return entry[1];
  endfunction

  function automatic logic entry_lru(tag_entry_t entry);
    return entry[0]; // Set means this way is the older one of the set.
  endfunction

  function automatic tag_entry_t make_entry(tag_t tag, logic valid, logic lru);
    return {tag, valid, lru};
  endfunction

endpackage

//--- cache_subsystem.sv
`timescale 1ns/1ps

module cache_subsystem (
  input  logic             clk,            // Cache clock.
  input  logic             reset,          // Synchronous, active high.
  input  logic             cpu_read,       // CPU read request.
  input  cache_pkg::addr_t cpu_address,    // CPU byte address.
  output cache_pkg::word_t cpu_data,       // Valid when stall is low.
  output logic             stall,          // Holds the CPU pipeline during a miss.
  output logic             mem_read,       // Word request to memory.
  output cache_pkg::addr_t mem_address,    // Byte address of the request.
  input  cache_pkg::word_t mem_data,       // Returned memory word.
  input  logic             mem_data_valid  // Qualifies mem_data.
);
  import cache_pkg::*;

  tag_t       address_tag;    // Tag field of the CPU address.
  index_t     address_index;  // Set field of the CPU address.
  offset_t    address_offset; // Word field of the CPU address.
  tag_entry_t way0_entry;     // Stored entry of way 0.
  tag_entry_t way1_entry;     // Stored entry of way 1.
  tag_entry_t way0_entry_in;  // Entry to write into way 0.
  tag_entry_t way1_entry_in;  // Entry to write into way 1.
  logic       way0_match;     // Hit in way 0.
  logic       way1_match;     // Hit in way 1.
  logic       tag_write;      // Tag array write enable.
  logic       data_write;     // Data array write enable.
  logic       write_way;      // Way being filled.
  offset_t    write_offset;   // Word being filled.
  word_t      fill_data;      // Word being stored.

  //////////////////////////////////////////////////////////////////////
  // Address split.
  //////////////////////////////////////////////////////////////////////
  assign address_tag    = addr_tag(cpu_address);
  assign address_index  = addr_index(cpu_address);
  assign address_offset = addr_offset(cpu_address);

  cache_control control_i (
    .clk            (clk),
    .reset          (reset),
    .cpu_read       (cpu_read),
    .cpu_address    (cpu_address),
    .way0_entry     (way0_entry),
    .way1_entry     (way1_entry),
    .way0_match     (way0_match),
    .way1_match     (way1_match),
    .mem_data       (mem_data),
    .mem_data_valid (mem_data_valid),
    .stall          (stall),
    .tag_write      (tag_write),
    .way0_entry_in  (way0_entry_in),
    .way1_entry_in  (way1_entry_in),
    .data_write     (data_write),
    .write_way      (write_way),
    .write_offset   (write_offset),
    .fill_data      (fill_data),
    .mem_read       (mem_read),
    .mem_address    (mem_address)
  );

  cache_tag_array tag_array_i (
    .clk           (clk),
    .reset         (reset),
    .index         (address_index),
    .tag           (address_tag),
    .tag_write     (tag_write),
    .way0_entry_in (way0_entry_in),
    .way1_entry_in (way1_entry_in),
    .way0_entry    (way0_entry),
    .way1_entry    (way1_entry),
    .way0_match    (way0_match),
    .way1_match    (way1_match)
  );

  // On a hit only one way matches, so way1_match alone selects the way.
  cache_data_array data_array_i (
    .clk          (clk),
    .index        (address_index),
    .read_offset  (address_offset),
    .read_way     (way1_match),
    .data_write   (data_write),
    .write_way    (write_way),
    .write_offset (write_offset),
    .fill_data    (fill_data),
    .read_data    (cpu_data)
  );

endmodule

//--- cache_tag_array.sv
`timescale 1ns/1ps

module cache_tag_array (
  input  logic                  clk,          // Cache clock.
  input  logic                  reset,        // Clears every entry to invalid.
  input  cache_pkg::index_t     index,        // Set selected by the CPU address.
  input  cache_pkg::tag_t       tag,          // Tag of the CPU address.
  input  logic                  tag_write,    // Writes both ways of the set.
  input  cache_pkg::tag_entry_t way0_entry_in, // New entry for way 0.
  input  cache_pkg::tag_entry_t way1_entry_in, // New entry for way 1.
  output cache_pkg::tag_entry_t way0_entry,   // Stored entry of way 0.
  output cache_pkg::tag_entry_t way1_entry,   // Stored entry of way 1.
  output logic                  way0_match,   // Way 0 holds the requested line.
  output logic                  way1_match    // Way 1 holds the requested line.
);
  import cache_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Entry storage.
  //////////////////////////////////////////////////////////////////////
  tag_entry_t way0_entries [num_sets]; // One entry per set in way 0.
  tag_entry_t way1_entries [num_sets]; // One entry per set in way 1.

  // Both ways of a set change together, since every write also moves
  // the LRU bit of the way that was not touched.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < num_sets; i++) begin
        way0_entries[i] <= '0; // Invalid, LRU clear.
        way1_entries[i] <= '0; // Invalid, LRU clear.
      end
    end else if (tag_write) begin
      way0_entries[index] <= way0_entry_in; // Hit update or new line.
      way1_entries[index] <= way1_entry_in; // Hit update or new line.
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Lookup and compare.
  //////////////////////////////////////////////////////////////////////
  assign way0_entry = way0_entries[index]; // Combinational read of the set.
  assign way1_entry = way1_entries[index]; // Combinational read of the set.

  // A way matches only when its entry is valid and the tags agree.
  assign way0_match = entry_valid(way0_entry) && (entry_tag(way0_entry) == tag);
  assign way1_match = entry_valid(way1_entry) && (entry_tag(way1_entry) == tag);

endmodule

//--- tb_cache_subsystem.sv
`timescale 1ns/1ps

module tb_cache_subsystem #(
  parameter int read_latency = 4 // Memory read latency in cycles.
);
  import cache_pkg::*;

  localparam int directed_reads = 24;  // Upper bound on the directed reads.
  localparam int random_reads   = 200; // Reads in the random sequence.
  localparam int miss_cycles    = line_words + read_latency + 3; // Longest read.
  localparam int cycle_limit    = (directed_reads + random_reads) * miss_cycles + 20;
  localparam addr_t line_a = {6'h01, 6'd5, 4'h0}; // Three lines that share set 5.
  localparam addr_t line_b = {6'h02, 6'd5, 4'h0};
  localparam addr_t line_c = {6'h03, 6'd5, 4'h0};

  logic        clk;
  logic        reset;
  logic        cpu_read;
  addr_t       cpu_address;
  word_t       cpu_data;
  logic        stall;
  logic        mem_read;
  addr_t       mem_address;
  word_t       mem_data;
  logic        mem_data_valid;
  logic [31:0] lfsr_state = 32'hb8fd_e17d; // Random source for addresses.
  int          cycle_count = 0;            // Cycles since time zero.
  tag_t        model_tag   [2][num_sets];  // Reference copy of the tags.
  logic        model_valid [2][num_sets];
  logic        model_lru   [2][num_sets];  // Set means the older way of the set.

  cache_subsystem cache_subsystem_i (
    .clk            (clk),
    .reset          (reset),
    .cpu_read       (cpu_read),
    .cpu_address    (cpu_address),
    .cpu_data       (cpu_data),
    .stall          (stall),
    .mem_read       (mem_read),
    .mem_address    (mem_address),
    .mem_data       (mem_data),
    .mem_data_valid (mem_data_valid)
  );

  tb_main_memory #(.read_latency(read_latency)) memory_i (
    .clk            (clk),
    .reset          (reset),
    .mem_read       (mem_read),
    .mem_address    (mem_address),
    .mem_data       (mem_data),
    .mem_data_valid (mem_data_valid)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period.
  end

  //////////////////////////////////////////////////////////////////////
  // Failure handling and the run limit.
  //////////////////////////////////////////////////////////////////////
  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    fail_run($sformatf("Error: %s expected 0x%0h actual 0x%0h", test, expected, actual));
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      fail_run($sformatf("Timeout: the run did not end within %0d cycles", cycle_limit));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Random addresses and the reference model.
  //////////////////////////////////////////////////////////////////////
  function automatic logic next_random_bit();
    logic bit_out;
    bit_out    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (bit_out) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003; // Galois taps.
    end
    return bit_out;
  endfunction

  function automatic logic [7:0] random_field(input int width);
    logic [7:0] value;
    value = '0;
    for (int i = 0; i < width; i++) begin
      value = {value[6:0], next_random_bit()}; // One LFSR step per bit.
    end
    return value;
  endfunction

  // Four tags over four sets, so two ways are not enough and lines get evicted.
  function automatic addr_t random_address();
    logic [7:0] tag_bits;
    logic [7:0] set_bits;
    logic [7:0] offset_bits;
    tag_bits    = random_field(2);
    set_bits    = random_field(2);
    offset_bits = random_field(3);
    return {4'b1001, tag_bits[1:0], 4'b0100, set_bits[1:0], offset_bits[2:0], 1'b0};
  endfunction

  // Same scramble as the memory contents, applied to the word address.
  function automatic word_t expected_word(input addr_t address);
    word_t word_address;
    word_address = {1'b0, address[15:1]};
    return (word_address * 16'h9e35) ^ {word_address[7:0], word_address[15:8]} ^ 16'h3c5a;
  endfunction

  function automatic int predict_way(input addr_t address); // Hit way, or -1 on a miss.
    int way;
    way = -1;
    for (int w = 0; w < 2; w++) begin
      if (model_valid[w][address[9:4]] && (model_tag[w][address[9:4]] == address[15:10])) begin
        way = w;
      end
    end
    return way;
  endfunction

  task automatic update_model(input addr_t address, input int hit_way);
    int     used;
    index_t set;
    set = address[9:4];
    if (hit_way >= 0) begin
      used = hit_way;
    end else begin
      used = model_lru[0][set] ? 0 : 1; // Way 0 goes when it is the older way.
      model_tag[used][set]   = address[15:10];
      model_valid[used][set] = 1'b1;
    end
    model_lru[used][set]     = 1'b0; // Most recently used.
    model_lru[1 - used][set] = 1'b1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // One CPU read, checked against the model.
  //////////////////////////////////////////////////////////////////////
  task automatic read_word(input addr_t address, input string test, input int expected_hit);
    int    hit_way;
    int    requests;
    addr_t base;
    addr_t expected_address;
    hit_way  = predict_way(address);
    requests = 0;
    base     = {address[15:4], 4'h0};
    if (expected_hit >= 0) begin // Directed reads also state the outcome they aim for.
      assert ((hit_way >= 0) == (expected_hit == 1))
        else report_mismatch({test, " predicted hit"}, 32'(expected_hit), 32'(hit_way >= 0));
    end
    cpu_read    = 1'b1;
    cpu_address = address;
    @(negedge clk);
    assert (stall == (hit_way < 0))
      else report_mismatch({test, " stall"}, 32'(hit_way < 0), 32'(stall));
    while (stall) begin // The CPU holds its request until stall falls.
      @(negedge clk);
      if (mem_read) begin
        expected_address = base + addr_t'(2 * requests);
        assert (mem_address == expected_address)
          else report_mismatch({test, " mem_address"}, 32'(expected_address), 32'(mem_address));
        requests++;
      end
    end
    assert (requests == ((hit_way < 0) ? line_words : 0))
      else report_mismatch({test, " request count"}, 32'((hit_way < 0) ? line_words : 0),
                           32'(requests));
    assert (!mem_read) else report_mismatch({test, " mem_read"}, 32'(0), 32'(mem_read));
    assert (cpu_data == expected_word(address))
      else report_mismatch({test, " cpu_data"}, 32'(expected_word(address)), 32'(cpu_data));
    update_model(address, hit_way);
    @(posedge clk);
    #1;
    cpu_read = 1'b0;
  endtask

  // Requests come only in a stall, and walk up the line a word at a time.
  assert property (@(posedge clk) disable iff (reset) mem_read |-> stall)
    else fail_run("mem_read was high while stall was low");
  assert property (@(posedge clk) disable iff (reset)
                   (mem_read && !$past(mem_read)) |-> (mem_address[3:0] == 4'h0))
    else fail_run("the first request of a fill was not line aligned");
  assert property (@(posedge clk) disable iff (reset)
                   (mem_read && $past(mem_read)) |-> (mem_address == $past(mem_address) + 16'd2))
    else fail_run("consecutive requests were not one word apart");
  assert property (@(posedge clk) disable iff (reset) !cpu_read |-> !stall)
    else fail_run("stall was high without a CPU read");

  //////////////////////////////////////////////////////////////////////
  // Stimulus.
  //////////////////////////////////////////////////////////////////////
  initial begin
    reset       = 1'b1;
    cpu_read    = 1'b0;
    cpu_address = '0;
    for (int w = 0; w < 2; w++) begin
      for (int s = 0; s < num_sets; s++) begin
        model_tag[w][s]   = '0; // Every entry starts invalid with LRU clear.
        model_valid[w][s] = 1'b0;
        model_lru[w][s]   = 1'b0;
      end
    end
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    assert (!stall) else report_mismatch("after_reset stall", 32'(0), 32'(stall));
    assert (!mem_read) else report_mismatch("after_reset mem_read", 32'(0), 32'(mem_read));
    @(posedge clk);
    #1;
    read_word(16'h1234, "first_read", 0);
    for (int i = 0; i < line_words; i++) begin
      read_word(16'h1230 + addr_t'(2 * i), $sformatf("line_hit_%0d", i), 1); // Whole line.
    end
    read_word(line_a, "lru_fill_a", 0);        // Goes to way 1.
    read_word(line_b, "lru_fill_b", 0);        // Goes to way 0.
    read_word(line_a + 16'd2, "lru_touch_a", 1); // Line B becomes the older one.
    read_word(line_c, "lru_fill_c", 0);        // Evicts B.
    read_word(line_a + 16'd6, "lru_kept_a", 1);
    read_word(line_b + 16'd8, "lru_evicted_b", 0); // Evicts C.
    read_word(line_c + 16'd4, "lru_evicted_c", 0); // Evicts A.
    read_word(line_b + 16'd14, "lru_kept_b", 1);
    for (int i = 0; i < random_reads; i++) begin
      read_word(random_address(), $sformatf("random_read_%0d", i), -1);
    end
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- tb_main_memory.sv
`timescale 1ns/1ps

module tb_main_memory #(
  parameter int read_latency = 4 // Cycles from a request to its returned word.
) (
  input  logic             clk,            // Memory clock, same as the cache.
  input  logic             reset,          // Empties the return pipeline.
  input  logic             mem_read,       // One word request.
  input  cache_pkg::addr_t mem_address,    // Byte address of the request.
  output cache_pkg::word_t mem_data,       // Returned word.
  output logic             mem_data_valid  // Qualifies mem_data.
);
  import cache_pkg::*;

  logic  valid_pipe   [read_latency]; // Request flags on their way back.
  addr_t address_pipe [read_latency]; // Request addresses on their way back.

  //////////////////////////////////////////////////////////////////////
  // Memory contents.
  //////////////////////////////////////////////////////////////////////
  // The word address is scrambled so neighbouring words look unrelated.
  function automatic word_t word_at(input addr_t address);
    word_t word_address;
    word_address = {1'b0, address[15:1]}; // Drop the byte bit.
    return (word_address * 16'h9e35) ^ {word_address[7:0], word_address[15:8]} ^ 16'h3c5a;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Fixed latency return pipeline.
  //////////////////////////////////////////////////////////////////////
  // A request enters stage 0 and leaves the last stage read_latency edges later.
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < read_latency; i++) begin
        valid_pipe[i]   <= 1'b0; // Nothing in flight.
        address_pipe[i] <= '0;
      end
    end else begin
      valid_pipe[0]   <= mem_read;
      address_pipe[0] <= mem_address;
      for (int i = 1; i < read_latency; i++) begin
        valid_pipe[i]   <= valid_pipe[i-1];   // Returns keep request order.
        address_pipe[i] <= address_pipe[i-1];
      end
    end
  end

  assign mem_data_valid = valid_pipe[read_latency-1];
  assign mem_data       = mem_data_valid ? word_at(address_pipe[read_latency-1]) : '0;

endmodule
